// ==== include/pmp_defs.svh ====
// PMP sizing macros for region count, granularity and address width
`ifndef PMP_DEFS_SVH
`define PMP_DEFS_SVH

// Number of PMP regions, each with one cfg field and one pmpaddr
`define PMP_NUM_REGIONS 4

// Granularity G, the smallest region is 2^(G+2) bytes
// NA4 cannot be selected once G is at least 1
`define PMP_GRANULARITY 2

// Width of a byte address and of a pmpaddr register
`define PMP_ADDR_W 32

// Index width derived from the region count
`define PMP_IDX_W $clog2(`PMP_NUM_REGIONS)

`endif

// ==== design/pmp_pkg.sv ====
// PMP package with the mode, privilege, access and CSR types shared by the unit
`include "pmp_defs.svh"

package pmp_pkg;

  // Address matching mode of a region
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // Privilege level, ISA encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'b00,
    ACC_WRITE = 2'b01,
    ACC_EXEC  = 2'b10
  } acc_type_e;

  // Which register the CSR port addresses
  typedef enum logic {
    CSR_CFG  = 1'b0,
    CSR_ADDR = 1'b1
  } csr_sel_e;

  // One pmpcfg field, ISA bit order
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef logic [`PMP_IDX_W-1:0] region_idx_t;

  typedef struct packed {
    logic                   we;
    csr_sel_e               sel;
    region_idx_t            idx;
    logic [`PMP_ADDR_W-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [`PMP_ADDR_W-1:0] addr;
    acc_type_e              acc_type;
    priv_e                  priv;
  } acc_req_t;

  // Access as seen by the second stage, with one match bit per region
  typedef struct packed {
    acc_req_t                   req;
    logic [`PMP_NUM_REGIONS-1:0] match;
  } match_stage_t;

  typedef struct packed {
    logic        allowed;
    logic        hit;
    region_idx_t hit_idx;
  } acc_res_t;

endpackage

// ==== design/pmp_csr_file.sv ====
// PMP CSR file holding legal cfg and pmpaddr values behind a four-phase port
`timescale 1ns/1ps
`include "pmp_defs.svh"

module pmp_csr_file (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         csr_req_valid_i,
  input  pmp_pkg::csr_req_t                            csr_req_i,
  output logic                                         csr_ack_o,
  output logic [31:0]                                  csr_rdata_o,
  output pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     cfg_o,
  output logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0] addr_o
);
  import pmp_pkg::*;

  typedef enum logic {
    IDLE,
    ACK
  } hs_state_e;

  hs_state_e                                    state_q;
  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]              cfg_q;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0] addr_q;
  logic [`PMP_NUM_REGIONS-1:0]                  addr_lock;
  logic [31:0]                                  rdata_q;
  logic [31:0]                                  rdata_d;
  logic                                         take;
  pmp_cfg_t                                     cfg_attempt;

  // Turn a write attempt into a legal cfg value
  function automatic pmp_cfg_t legalize_cfg(pmp_cfg_t old_cfg, pmp_cfg_t attempt);
    pmp_cfg_t res;
    res = attempt;
    // W without R is reserved, keep the old permissions
    if (attempt.write && !attempt.read) begin
      res.read  = old_cfg.read;
      res.write = old_cfg.write;
      res.exec  = old_cfg.exec;
    end
    if ((`PMP_GRANULARITY >= 1) && (attempt.mode == PMP_NA4)) begin
      res.mode = old_cfg.mode;
    end
    if (old_cfg.lock) begin
      res = old_cfg;
    end
    res.zero = 2'b00;
    return res;
  endfunction

  // Software view of pmpaddr, the stored value is untouched
  function automatic logic [`PMP_ADDR_W-1:0] addr_view(logic [`PMP_ADDR_W-1:0] raw,
                                                       pmp_mode_e mode);
    logic [`PMP_ADDR_W-1:0] view;
    view = raw;
    for (int b = 0; b < `PMP_GRANULARITY; b++) begin
      if ((mode == PMP_NAPOT) && (b < `PMP_GRANULARITY - 1)) begin
        view[b] = 1'b1;
      end else if (!mode[1]) begin
        // OFF and TOR
        view[b] = 1'b0;
      end
    end
    return view;
  endfunction

  // New request while idle
  assign take        = (state_q == IDLE) && csr_req_valid_i;
  assign cfg_attempt = pmp_cfg_t'(csr_req_i.wdata[7:0]);

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_region
    if (i < `PMP_NUM_REGIONS - 1) begin : gen_tor_above
      // A locked TOR entry above also freezes this address
      assign addr_lock[i] = cfg_q[i].lock ||
                            (cfg_q[i+1].lock && (cfg_q[i+1].mode == PMP_TOR));
    end else begin : gen_top_entry
      assign addr_lock[i] = cfg_q[i].lock;
    end

    assign addr_o[i] = addr_view(addr_q[i], cfg_q[i].mode);

    // Lock holds until reset
    a_lock_stable: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cfg_q[i].lock |=> $stable(cfg_q[i])
    );
  end

  always_comb begin
    if (csr_req_i.sel == CSR_CFG) begin
      rdata_d = {24'h00_0000, cfg_q[csr_req_i.idx]};
    end else begin
      rdata_d = addr_o[csr_req_i.idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (csr_req_valid_i) state_q <= ACK;
        ACK:     if (!csr_req_valid_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else if (take && csr_req_i.we) begin
      if (csr_req_i.sel == CSR_CFG) begin
        cfg_q[csr_req_i.idx] <= legalize_cfg(cfg_q[csr_req_i.idx], cfg_attempt);
      end else if (!addr_lock[csr_req_i.idx]) begin
        addr_q[csr_req_i.idx] <= csr_req_i.wdata;
      end
    end
  end

  // Read data shows the value before the write
  always_ff @(posedge clk_i) begin
    if (take) begin
      rdata_q <= rdata_d;
    end
  end

  assign csr_ack_o   = (state_q == ACK);
  assign csr_rdata_o = rdata_q;
  assign cfg_o       = cfg_q;

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(csr_ack_o) |-> $past(csr_req_valid_i)
  );

endmodule

// ==== design/pmp_match_stage.sv ====
// PMP match stage, registers an access and its per-region address match vector
`timescale 1ns/1ps
`include "pmp_defs.svh"

module pmp_match_stage (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         acc_valid_i,
  input  pmp_pkg::acc_req_t                            acc_req_i,
  input  pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     cfg_i,
  input  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0] addr_i,
  output logic                                         stage_valid_o,
  output pmp_pkg::match_stage_t                        stage_o
);
  import pmp_pkg::*;

  logic                        stage_valid_q;
  match_stage_t                stage_q;
  logic [`PMP_ADDR_W-1:0]      word_addr;
  logic [`PMP_NUM_REGIONS-1:0] match_d;

  // pmpaddr holds address bits 33:2
  assign word_addr = acc_req_i.addr >> 2;

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : gen_match
    logic [`PMP_ADDR_W-1:0] lower;
    logic [`PMP_ADDR_W-1:0] napot_mask;
    logic                   hit;

    if (i == 0) begin : gen_base
      assign lower = '0;
    end else begin : gen_prev
      assign lower = addr_i[i-1];
    end

    // Trailing ones and the bit above them are don't care
    assign napot_mask = ~(addr_i[i] ^ (addr_i[i] + 1'b1));

    always_comb begin
      case (cfg_i[i].mode)
        PMP_TOR: begin
          hit = (lower <= word_addr) && (word_addr < addr_i[i]);
        end
        PMP_NA4: begin
          hit = (word_addr == addr_i[i]);
        end
        PMP_NAPOT: begin
          hit = ((word_addr ^ addr_i[i]) & napot_mask) == '0;
        end
        default: begin
          hit = 1'b0;
        end
      endcase
    end

    assign match_d[i] = hit;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= 1'b0;
    end else begin
      stage_valid_q <= acc_valid_i;
    end
  end

  // Payload only moves with a valid access
  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      stage_q.req   <= acc_req_i;
      stage_q.match <= match_d;
    end
  end

  assign stage_valid_o = stage_valid_q;
  assign stage_o       = stage_q;

endmodule

// ==== design/pmp_decide_stage.sv ====
// PMP decide stage that picks the lowest matching region and grants or denies the access
`timescale 1ns/1ps
`include "pmp_defs.svh"

module pmp_decide_stage (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     stage_valid_i,
  input  pmp_pkg::match_stage_t                    stage_i,
  input  pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0] cfg_i,
  output logic                                     res_valid_o,
  output pmp_pkg::acc_res_t                        res_o
);
  import pmp_pkg::*;

  logic        hit_d;
  region_idx_t idx_d;
  pmp_cfg_t    sel_cfg;
  logic        perm;
  logic        allowed_d;
  logic        res_valid_q;
  acc_res_t    res_q;

  // Lowest index wins, so scan from the top down
  always_comb begin
    hit_d = 1'b0;
    idx_d = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (stage_i.match[i]) begin
        hit_d = 1'b1;
        idx_d = region_idx_t'(i);
      end
    end
  end

  assign sel_cfg = cfg_i[idx_d];

  always_comb begin
    case (stage_i.req.acc_type)
      ACC_READ:  perm = sel_cfg.read;
      ACC_WRITE: perm = sel_cfg.write;
      ACC_EXEC:  perm = sel_cfg.exec;
      default:   perm = 1'b0;
    endcase
  end

  // M-mode ignores unlocked regions and U-mode needs a hit
  always_comb begin
    if (hit_d) begin
      allowed_d = ((stage_i.req.priv == PRIV_M) && !sel_cfg.lock) || perm;
    end else begin
      allowed_d = (stage_i.req.priv == PRIV_M);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= stage_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_valid_i) begin
      res_q.allowed <= allowed_d;
      res_q.hit     <= hit_d;
      res_q.hit_idx <= idx_d;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  // Result one cycle after its stage entry, hit only when some region matched
  a_fixed_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stage_valid_i |=> res_valid_o && (res_o.hit == (|$past(stage_i.match)))
  );

endmodule

// ==== design/pmp_top.sv ====
// PMP unit top level joining the CSR file and the two-stage access check
`timescale 1ns/1ps
`include "pmp_defs.svh"

module pmp_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  csr_req_valid_i,
  input  pmp_pkg::csr_req_t     csr_req_i,
  output logic                  csr_ack_o,
  output logic [31:0]           csr_rdata_o,
  input  logic                  acc_valid_i,
  input  pmp_pkg::acc_req_t     acc_req_i,
  output logic                  res_valid_o,
  output pmp_pkg::acc_res_t     res_o
);
  import pmp_pkg::*;

  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]              cfg;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0] addr;
  logic                                         stage_valid;
  match_stage_t                                 stage;

  pmp_csr_file u_csr_file (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_req_i       (csr_req_i),
    .csr_ack_o       (csr_ack_o),
    .csr_rdata_o     (csr_rdata_o),
    .cfg_o           (cfg),
    .addr_o          (addr)
  );

  // Addresses reach the matcher in their granularity view
  pmp_match_stage u_match (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acc_valid_i   (acc_valid_i),
    .acc_req_i     (acc_req_i),
    .cfg_i         (cfg),
    .addr_i        (addr),
    .stage_valid_o (stage_valid),
    .stage_o       (stage)
  );

  pmp_decide_stage u_decide (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stage_valid_i (stage_valid),
    .stage_i       (stage),
    .cfg_i         (cfg),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o)
  );

endmodule

// ==== tests/pmp_tb.sv ====
// PMP unit testbench with a reference model, CSR and access checks and a result summary
`timescale 1ns/1ps
`include "pmp_defs.svh"

module pmp_tb;
  import pmp_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND_CFG = 64;
  localparam int N_ACCESS   = 200;
  // Reset, CSR and access operations over all tests
  localparam int TOTAL_OPS  = 10 + 2 * N_RAND_CFG + 40 + 48 + 20 + N_ACCESS;
  localparam int TIMEOUT_NS = TOTAL_OPS * 8 * CLK_PERIOD * 2;

  logic        clk_i;
  logic        rst_ni;
  logic        csr_req_valid_i;
  csr_req_t    csr_req_i;
  logic        csr_ack_o;
  logic [31:0] csr_rdata_o;
  logic        acc_valid_i;
  acc_req_t    acc_req_i;
  logic        res_valid_o;
  acc_res_t    res_o;

  pmp_cfg_t    ref_cfg  [`PMP_NUM_REGIONS];
  logic [31:0] ref_addr [`PMP_NUM_REGIONS];
  acc_res_t    exp_res_q[$];
  int          exp_cycle_q[$];
  int          cycle;
  int          errors;
  int          checks;
  int          tests;

  pmp_top u_pmp_top (
    .clk_i, .rst_ni, .csr_req_valid_i, .csr_req_i, .csr_ack_o, .csr_rdata_o,
    .acc_valid_i, .acc_req_i, .res_valid_o, .res_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Reference rules for a cfg write
  function automatic pmp_cfg_t legal_cfg(pmp_cfg_t old_cfg, pmp_cfg_t attempt);
    pmp_cfg_t res;
    if (old_cfg.lock) return old_cfg;
    res = attempt;
    res.zero = 2'b00;
    if (attempt.write && !attempt.read) {res.read, res.write, res.exec} =
        {old_cfg.read, old_cfg.write, old_cfg.exec};
    if (`PMP_GRANULARITY >= 1 && attempt.mode == PMP_NA4) res.mode = old_cfg.mode;
    return res;
  endfunction

  function automatic logic [31:0] view_addr(logic [31:0] raw, pmp_mode_e mode);
    if (mode == PMP_NAPOT) return raw | ((32'd1 << (`PMP_GRANULARITY - 1)) - 32'd1);
    if (mode == PMP_NA4) return raw;
    return raw & ~((32'd1 << `PMP_GRANULARITY) - 32'd1);
  endfunction

  function automatic logic [31:0] ref_readback(csr_sel_e sel, int idx);
    if (sel == CSR_CFG) return {24'h0, ref_cfg[idx]};
    return view_addr(ref_addr[idx], ref_cfg[idx].mode);
  endfunction

  function automatic void ref_write(csr_sel_e sel, int idx, logic [31:0] wdata);
    logic frozen;
    if (sel == CSR_CFG) begin
      ref_cfg[idx] = legal_cfg(ref_cfg[idx], pmp_cfg_t'(wdata[7:0]));
    end else begin
      frozen = ref_cfg[idx].lock;
      if (idx + 1 < `PMP_NUM_REGIONS)
        frozen |= ref_cfg[idx+1].lock && ref_cfg[idx+1].mode == PMP_TOR;
      if (!frozen) ref_addr[idx] = wdata;
    end
  endfunction

  function automatic logic region_hit(int i, logic [31:0] word);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] care;
    int          ones;
    hi = view_addr(ref_addr[i], ref_cfg[i].mode);
    lo = 32'h0;
    if (i > 0) lo = view_addr(ref_addr[i-1], ref_cfg[i-1].mode);
    case (ref_cfg[i].mode)
      PMP_TOR: return word >= lo && word < hi;
      PMP_NA4: return word == hi;
      PMP_NAPOT: begin
        // Trailing ones plus the next bit give the region size
        ones = 0;
        while (ones < 32 && hi[ones]) ones++;
        care = '1;
        for (int b = 0; b <= ones && b < 32; b++) care[b] = 1'b0;
        return (word & care) == (hi & care);
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic acc_res_t ref_access(acc_req_t req);
    acc_res_t res;
    pmp_cfg_t c;
    logic     perm;
    res = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (!res.hit && region_hit(i, {2'b00, req.addr[31:2]})) begin
        res.hit     = 1'b1;
        res.hit_idx = region_idx_t'(i);
      end
    end
    c = ref_cfg[res.hit_idx];
    perm = (req.acc_type == ACC_READ) ? c.read : (req.acc_type == ACC_WRITE) ? c.write : c.exec;
    if (!res.hit) begin
      // Outside every region only M-mode passes
      res.allowed = (req.priv == PRIV_M);
    end else if (req.priv == PRIV_M && !c.lock) begin
      res.allowed = 1'b1;
    end else begin
      res.allowed = perm;
    end
    return res;
  endfunction

  function automatic acc_req_t make_req();
    acc_req_t req;
    case ($urandom_range(0, 3))
      0, 1:    req.addr = $urandom_range(0, 32'h5fff);
      2:       req.addr = 32'h8000_0000 + $urandom_range(0, 32'h13fff);
      default: req.addr = $urandom;
    endcase
    case ($urandom_range(0, 2))
      0:       req.acc_type = ACC_READ;
      1:       req.acc_type = ACC_WRITE;
      default: req.acc_type = ACC_EXEC;
    endcase
    req.priv = $urandom_range(0, 1) ? PRIV_M : PRIV_U;
    return req;
  endfunction

  // One four-phase transfer with its read data checked against the pre-write model
  task automatic csr_op(input logic we, input csr_sel_e sel, input int idx,
                        input logic [31:0] wdata, output logic [31:0] rdata);
    logic [31:0] exp_rdata;
    int          waited;
    exp_rdata = ref_readback(sel, idx);
    @(negedge clk_i);
    csr_req_i       = '{we: we, sel: sel, idx: region_idx_t'(idx), wdata: wdata};
    csr_req_valid_i = 1'b1;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!csr_ack_o && waited < 16);
    rdata = csr_rdata_o;
    if (!csr_ack_o) begin
      $display("CSR handshake timed out, no ack after %0d cycles", waited);
      errors++;
    end else begin
      checks++;
      assert (rdata === exp_rdata) else begin
        $display("CHECK FAILED csr_rdata_o got %h expected %h", rdata, exp_rdata);
        errors++;
      end
      if (we) ref_write(sel, idx, wdata);
    end
    csr_req_valid_i = 1'b0;
    waited = 0;
    while (csr_ack_o && waited < 16) begin
      @(negedge clk_i);
      waited++;
    end
    if (csr_ack_o) begin
      $display("CSR ack still high %0d cycles after req was dropped", waited);
      errors++;
    end
  endtask

  task automatic write_reg(input csr_sel_e sel, input int idx, input logic [31:0] wdata);
    logic [31:0] unused;
    csr_op(1'b1, sel, idx, wdata, unused);
  endtask

  task automatic read_all();
    logic [31:0] rd;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      csr_op(1'b0, CSR_CFG, i, 32'h0, rd);
      csr_op(1'b0, CSR_ADDR, i, 32'h0, rd);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      ref_cfg[i]  = '0;
      ref_addr[i] = '0;
    end
    exp_res_q.delete();
    exp_cycle_q.delete();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - err_start);
  endtask

  // Access results in arrival order with their due cycle
  initial begin : compare_results
    acc_res_t exp;
    int       due;
    forever begin
      @(negedge clk_i);
      if (rst_ni && res_valid_o) begin
        if (exp_res_q.size() == 0) begin
          $display("Access result arrived while no access was pending");
          errors++;
        end else begin
          exp = exp_res_q.pop_front();
          due = exp_cycle_q.pop_front();
          checks++;
          assert (cycle == due) else begin
            $display("Access result arrived in cycle %0d instead of cycle %0d", cycle, due);
            errors++;
          end
          assert (res_o === exp) else begin
            $display("CHECK FAILED res_o got %h expected %h", res_o, exp);
            errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Run stopped by the watchdog after %0d ns", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    int          err_start;
    int          waited;
    logic [31:0] rd;
    logic [31:0] napot_rd;
    logic [31:0] wdata;
    acc_req_t    req;
    void'($urandom(32'h1390_1e2f));
    {rst_ni, csr_req_valid_i, acc_valid_i} = 3'b000;
    {csr_req_i, acc_req_i, errors, checks, tests} = '0;
    apply_reset();

    err_start = errors;
    @(negedge clk_i);
    checks++;
    assert (csr_ack_o === 1'b0 && res_valid_o === 1'b0) else begin
      $display("CHECK FAILED csr_ack_o got %h res_valid_o got %h expected 0 0",
               csr_ack_o, res_valid_o);
      errors++;
    end
    read_all();
    report_test("reset state", err_start);

    err_start = errors;
    for (int n = 0; n < N_RAND_CFG; n++) begin
      wdata    = $urandom;
      wdata[7] = ($urandom_range(0, 7) == 0);
      write_reg(CSR_CFG, n % `PMP_NUM_REGIONS, wdata);
      csr_op(1'b0, CSR_CFG, n % `PMP_NUM_REGIONS, 32'h0, rd);
    end
    report_test("cfg legalization", err_start);

    err_start = errors;
    apply_reset();
    for (int i = 0; i < 3; i++) write_reg(CSR_ADDR, i, 32'h100 * (i + 1));
    write_reg(CSR_CFG, 1, 32'h8d);
    write_reg(CSR_CFG, 1, 32'h1f);
    write_reg(CSR_ADDR, 1, 32'hdead_beef);
    write_reg(CSR_ADDR, 0, 32'h1234_5678);
    write_reg(CSR_CFG, 2, 32'h99);
    write_reg(CSR_ADDR, 2, 32'hffff_0000);
    write_reg(CSR_CFG, 2, 32'h00);
    write_reg(CSR_ADDR, 3, 32'h0abc_def0);
    write_reg(CSR_CFG, 0, 32'h0f);
    read_all();
    apply_reset();
    read_all();
    write_reg(CSR_ADDR, 0, 32'h5555_aaaa);
    read_all();
    report_test("lock rules", err_start);

    err_start = errors;
    apply_reset();
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      write_reg(CSR_ADDR, i, $urandom);
      write_reg(CSR_CFG, i, 32'h19);
      csr_op(1'b0, CSR_ADDR, i, 32'h0, napot_rd);
      write_reg(CSR_CFG, i, 32'h09);
      csr_op(1'b0, CSR_ADDR, i, 32'h0, rd);
      write_reg(CSR_CFG, i, 32'h00);
      csr_op(1'b0, CSR_ADDR, i, 32'h0, rd);
      write_reg(CSR_CFG, i, 32'h19);
      write_reg(CSR_CFG, i, 32'h11);
      csr_op(1'b0, CSR_ADDR, i, 32'h0, rd);
      checks++;
      assert (rd === napot_rd) else begin
        $display("CHECK FAILED csr_rdata_o got %h expected %h", rd, napot_rd);
        errors++;
      end
    end
    report_test("granularity view", err_start);

    err_start = errors;
    apply_reset();
    // Overlapping TOR and NAPOT regions where region 2 is locked with X only
    write_reg(CSR_ADDR, 0, 32'h0000_0400);
    write_reg(CSR_ADDR, 1, 32'h0000_03ff);
    write_reg(CSR_ADDR, 2, 32'h0000_4000);
    write_reg(CSR_ADDR, 3, 32'h2000_1fff);
    write_reg(CSR_CFG, 0, 32'h0d);
    write_reg(CSR_CFG, 1, 32'h1b);
    write_reg(CSR_CFG, 2, 32'h8c);
    write_reg(CSR_CFG, 3, 32'h1f);
    for (int n = 0; n < N_ACCESS; n++) begin
      @(negedge clk_i);
      acc_valid_i = ($urandom_range(0, 3) != 0);
      if (acc_valid_i) begin
        req       = make_req();
        acc_req_i = req;
        exp_res_q.push_back(ref_access(req));
        exp_cycle_q.push_back(cycle + 2);
      end
    end
    @(negedge clk_i);
    acc_valid_i = 1'b0;
    waited = 0;
    while (exp_res_q.size() != 0 && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_res_q.size() != 0) begin
      $display("%0d access results never arrived", exp_res_q.size());
      errors++;
    end
    report_test("access checks", err_start);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
design/pmp_pkg.sv
design/pmp_csr_file.sv
design/pmp_match_stage.sv
design/pmp_decide_stage.sv
design/pmp_top.sv
tests/pmp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := pmp_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
